//--- bench/mmio_assert.sv
/*
 * MMIO protocol assertions
 * Bound onto the subsystem top level to check the select and ready pulses.
 */

`timescale 1ns/10ps

module mmio_assert (
    input logic                    vdp_clk,
    input logic                    vdp_reset,
    input mmio_bus_pkg::mmio_sel_t sel,
    input mmio_bus_pkg::mmio_rsp_t rsp
);

    logic [4:0] regions;

    assign regions = {sel.status, sel.dsp, sel.pad, sel.cop, sel.none};

    // ready lasts one cycle
    ready_pulse: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        rsp.ready |=> !rsp.ready)
        else $error("ready stayed high for more than one cycle");

    sel_onehot: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $onehot0(regions))
        else $error("more than one region select high");

    // ready exactly one cycle after the select
    sel_to_ready: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        (|regions) |=> rsp.ready)
        else $error("no ready one cycle after a select");

    ready_from_sel: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        rsp.ready |-> $past(|regions))
        else $error("ready without a select one cycle earlier");

endmodule

bind mmio_subsystem mmio_assert assertions (
    .vdp_clk  (vdp_clk),
    .vdp_reset(vdp_reset),
    .sel      (sel),
    .rsp      (rsp)
);

//--- bench/tb_mmio.sv
/*
 * MMIO subsystem testbench
 * Directed bus tests for the status LEDs, access latency, dsp product,
 * gamepad shift port, copper RAM and unmapped regions.
 */

`timescale 1ns/10ps

module tb_mmio;
    import mmio_bus_pkg::*;
    import mmio_periph_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int READY_TIMEOUT = 20;
    // about 140 accesses of 3 cycles, reset, copper reads and a margin
    localparam int RUN_CYCLES    = 16 + 140 * 3 + 300;

    logic                  vdp_clk;
    logic                  vdp_reset;
    mmio_req_t             req;
    mmio_rsp_t             rsp;
    pad_buttons_t          buttons;
    logic                  led_r;
    logic                  led_b;
    logic                  cop_read_en;
    logic [COP_ADDR_W-1:0] cop_read_address;
    logic [15:0]           cop_read_data;
    int                    check_count;
    int                    error_count;

    mmio_subsystem dut (.*);

    initial begin
        vdp_clk = 1'b0;
        forever #(CLK_PERIOD / 2) vdp_clk = ~vdp_clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("ERR %s exp=%h got=%h", name, expected, actual);
        end
    endtask

    function automatic logic [23:0] region_address(input logic [3:0] region,
                                                   input logic [15:0] offset);
        return {4'h0, region, offset};
    endfunction

    // valid held until ready, dropped on the falling edge that sees it
    task automatic issue_request(input logic [23:0] address, input logic [3:0] wstrb,
                                 input logic [31:0] write_data,
                                 output logic [31:0] read_data);
        int cycles;
        @(negedge vdp_clk);
        req.valid      = 1'b1;
        req.address    = address;
        req.wstrb      = wstrb;
        req.write_data = write_data;
        cycles         = 0;
        do begin
            @(negedge vdp_clk);
            cycles++;
        end while (!rsp.ready && cycles < READY_TIMEOUT);
        read_data = rsp.read_data;
        check_count++;
        assert (rsp.ready) else begin
            error_count++;
            $display("no ready pulse within %0d cycles for address %h", cycles, address);
        end
        check_value("rsp.ready latency", 32'd2, 32'(cycles));
        req = '0;
    endtask

    // a write answers with zero read data
    task automatic bus_write(input logic [23:0] address, input logic [3:0] wstrb,
                             input logic [31:0] write_data);
        logic [31:0] data;
        issue_request(address, wstrb, write_data, data);
        check_value("rsp.read_data", 32'h0, data);
    endtask

    task automatic bus_read(input logic [23:0] address, output logic [31:0] read_data);
        issue_request(address, 4'b0000, $urandom, read_data);
    endtask

    task automatic reset_and_status();
        logic [1:0]  value;
        logic [31:0] data;
        check_value("rsp.ready", 32'd0, {31'b0, rsp.ready});
        // red LED on, blue LED off
        check_value("led_r", 32'd1, {31'b0, led_r});
        check_value("led_b", 32'd0, {31'b0, led_b});
        bus_read(region_address(REGION_STATUS, 16'h0), data);
        check_value("rsp.read_data", 32'h1, data);
        // second value is the inverse, so at least one differs from reset
        for (int i = 0; i < 2; i++) begin
            value = (i == 0) ? 2'($urandom) : ~value;
            bus_write(region_address(REGION_STATUS, 16'h0), 4'b0001, {30'b0, value});
            check_value("led_r", {31'b0, value[0]}, {31'b0, led_r});
            check_value("led_b", {31'b0, value[1]}, {31'b0, led_b});
            bus_read(region_address(REGION_STATUS, 16'h0), data);
            check_value("rsp.read_data", {30'b0, value}, data);
        end
    endtask

    task automatic access_latency();
        logic [31:0] data;
        // region 4 is unmapped
        for (int r = 0; r < 5; r++) begin
            bus_read(region_address(4'(r), 16'h0), data);
        end
        bus_write(region_address(REGION_STATUS, 16'h0), 4'b0001, 32'h1);
        repeat (4) begin
            @(negedge vdp_clk);
            check_count++;
            assert (!rsp.ready) else begin
                error_count++;
                $display("a second ready pulse came after the request had completed");
            end
        end
    endtask

    task automatic dsp_product();
        logic [15:0] a;
        logic [15:0] b;
        int          expected;
        logic [31:0] data;
        for (int i = 0; i < 4; i++) begin
            a = (i == 0) ? 16'h8000 : 16'($urandom);
            b = (i == 0) ? 16'h8000 : 16'($urandom);
            bus_write(region_address(REGION_DSP, 16'h0), 4'b0011, {16'($urandom), a});
            bus_write(region_address(REGION_DSP, 16'h4), 4'b0011, {16'($urandom), b});
            bus_read(region_address(REGION_DSP, 16'h0), data);
            expected = int'($signed(a)) * int'($signed(b));
            check_value("rsp.read_data", expected, data);
        end
    endtask

    task automatic pad_shift_sequence(input pad_buttons_t pattern);
        logic [PAD_SHIFT_W:0] image;
        logic [23:0]          pad_address;
        logic [31:0]          data;
        // one spare zero bit above the register for the last read
        image       = '0;
        image[15]   = pattern.left;
        image[14]   = pattern.right;
        image[8]    = pattern.b;
        pad_address = region_address(REGION_PAD, 16'h0);
        buttons     = pattern;
        bus_write(pad_address, 4'b0001, 32'(1 << PAD_LATCH_BIT));
        bus_write(pad_address, 4'b0001, 32'h0);
        for (int k = 0; k <= PAD_SHIFT_W; k++) begin
            if (k > 0) begin
                bus_write(pad_address, 4'b0001, 32'(1 << PAD_CLK_BIT));
                bus_write(pad_address, 4'b0001, 32'h0);
            end
            bus_read(pad_address, data);
            check_value("rsp.read_data", {31'b0, image[k]}, data);
        end
    endtask

    task automatic copper_ram_readback();
        logic [9:0]            word;
        logic [COP_ADDR_W-1:0] index [8];
        logic [15:0]           expected [8];
        logic [31:0]           data;
        // spaced word addresses so no two writes collide
        for (int i = 0; i < 8; i++) begin
            word        = 10'(i * 97 + $urandom_range(7, 0));
            index[i]    = {word, i[0]};
            data        = $urandom;
            expected[i] = data[15:0];
            bus_write(region_address(REGION_COP, {4'h0, word, 2'b00}),
                      i[0] ? 4'b1100 : 4'b0011, data);
        end
        for (int i = 0; i < 8; i++) begin
            cop_read_en      = 1'b1;
            cop_read_address = index[i];
            @(negedge vdp_clk);
            cop_read_en = 1'b0;
            check_value("cop_read_data", {16'b0, expected[i]}, {16'b0, cop_read_data});
        end
    endtask

    task automatic unmapped_read();
        logic [31:0] data;
        bus_read(region_address(4'hA, 16'h0040), data);
        check_value("rsp.read_data", 32'h0, data);
        bus_read(region_address(REGION_COP, 16'h0008), data);
        check_value("rsp.read_data", 32'h0, data);
    endtask

    initial begin
        pad_buttons_t pattern;
        vdp_reset        = 1'b1;
        req              = '0;
        buttons          = '0;
        cop_read_en      = 1'b0;
        cop_read_address = '0;
        check_count      = 0;
        error_count      = 0;
        void'($urandom(32'hb560e05a));
        repeat (16) @(negedge vdp_clk);
        vdp_reset = 1'b0;

        reset_and_status();
        access_latency();
        dsp_product();
        pattern = 3'($urandom);
        pad_shift_sequence(pattern);
        pad_shift_sequence(pad_buttons_t'(~pattern));
        copper_ram_readback();
        unmapped_read();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- mmio_subsys.f
src/mmio_bus_pkg.sv
src/mmio_periph_pkg.sv
src/mmio_decoder.sv
src/mmio_read_mux.sv
src/dsp_mult.sv
src/io_ports.sv
src/cop_ram.sv
src/mmio_subsystem.sv
bench/mmio_assert.sv
bench/tb_mmio.sv

//--- run_sim.sh
#!/bin/sh
# build and run the MMIO subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mmio -f mmio_subsys.f \
    --Mdir obj_dir -o tb_mmio_sim

./obj_dir/tb_mmio_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- src/cop_ram.sv
/*
 * Copper RAM
 * 2048 x 16 simple dual-port block RAM holding the display list. The CPU
 * writes it, the video side reads it with one cycle of latency.
 */

`timescale 1ns/10ps

module cop_ram (
    input  logic                                vdp_clk,
    input  logic                                write_en,
    input  logic [mmio_bus_pkg::COP_ADDR_W-1:0] write_address,
    input  logic [15:0]                         write_data,
    input  logic                                read_en,
    input  logic [mmio_bus_pkg::COP_ADDR_W-1:0] read_address,
    output logic [15:0]                         read_data
);
    import mmio_bus_pkg::*;

    logic [15:0] mem [0:(1 << COP_ADDR_W) - 1];

    always_ff @(posedge vdp_clk) begin
        if (write_en) begin
            mem[write_address] <= write_data;
        end
    end

    // registered read, data holds while read_en is low
    always_ff @(posedge vdp_clk) begin
        if (read_en) begin
            read_data <= mem[read_address];
        end
    end

endmodule

//--- src/dsp_mult.sv
/*
 * DSP multiplier
 * Two 16 bit operand registers and a registered signed 32 bit product,
 * written so the whole block maps onto one MAC16 cell.
 */

`timescale 1ns/10ps

module dsp_mult (
    input  logic        vdp_clk,
    input  logic        sel_dsp,
    input  logic        write,
    input  logic        operand_b_sel,
    input  logic [15:0] write_data,
    output logic [31:0] result
);

    logic signed [15:0] operand_a;
    logic signed [15:0] operand_b;
    logic               load_a;
    logic               load_b;

    assign load_a = sel_dsp && write && !operand_b_sel;
    assign load_b = sel_dsp && write && operand_b_sel;

    // enables kept flat, nested ifs push the operands out to fabric FFs
    always_ff @(posedge vdp_clk) begin
        if (load_a) begin
            operand_a <= write_data;
        end

        if (load_b) begin
            operand_b <= write_data;
        end
    end

    // product follows the operands every cycle
    always_ff @(posedge vdp_clk) begin
        result <= operand_a * operand_b;
    end

endmodule

//--- src/io_ports.sv
/*
 * Status LEDs and gamepad port
 * Holds the two LED bits and a software driven gamepad latch/clock
 * port whose shift register returns one button bit per read.
 */

`timescale 1ns/10ps

module io_ports (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,
    input  logic                          sel_status,
    input  logic                          sel_pad,
    input  logic                          write,
    input  logic [1:0]                    write_data,
    input  mmio_periph_pkg::pad_buttons_t buttons,
    output logic [1:0]                    status,
    output logic                          led_r,
    output logic                          led_b,
    output logic                          pad_bit
);
    import mmio_periph_pkg::*;

    logic [1:0]             pad_ctrl;
    logic                   pad_latch;
    logic                   pad_clk;
    logic                   pad_clk_q;
    logic [PAD_SHIFT_W-1:0] pad_shift;

    // status register
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= STATUS_RESET;
        end else if (sel_status && write) begin
            status <= write_data;
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

    // pad control, latch and clock driven by software
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl  <= '0;
            pad_clk_q <= 1'b0;
        end else begin
            if (sel_pad && write) begin
                pad_ctrl <= write_data;
            end
            pad_clk_q <= pad_clk;
        end
    end

    assign pad_latch = pad_ctrl[PAD_LATCH_BIT];
    assign pad_clk   = pad_ctrl[PAD_CLK_BIT];

    // left, right, five zeros, then b
    always_ff @(posedge vdp_clk) begin
        if (pad_latch) begin
            pad_shift <= {buttons.left, buttons.right, 5'b0, buttons.b, 8'b0};
        end else if (pad_clk && !pad_clk_q) begin
            pad_shift <= {1'b0, pad_shift[PAD_SHIFT_W-1:1]};
        end
    end

    assign pad_bit = pad_shift[0];

endmodule

//--- src/mmio_bus_pkg.sv
/*
 * MMIO bus definitions
 * Request, response and select structs shared by the decoder, the read mux
 * and the top level, plus the region map of the peripheral address space.
 */

package mmio_bus_pkg;

    // one bus request, held by the master until ready
    typedef struct packed {
        logic        valid;
        logic [23:0] address;
        logic [3:0]  wstrb;
        logic [31:0] write_data;
    } mmio_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] read_data;
    } mmio_rsp_t;

    // one-cycle select pulses, at most one region bit high
    typedef struct packed {
        logic status;
        logic dsp;
        logic pad;
        logic cop;
        logic none;
        logic write;
    } mmio_sel_t;

    // region field of the address
    localparam int REGION_MSB = 19;
    localparam int REGION_LSB = 16;

    localparam logic [3:0] REGION_STATUS = 4'd0;
    localparam logic [3:0] REGION_DSP    = 4'd1;
    localparam logic [3:0] REGION_PAD    = 4'd2;
    localparam logic [3:0] REGION_COP    = 4'd3;

    // copper RAM holds 2048 words
    localparam int COP_ADDR_W = 11;

endpackage

//--- src/mmio_decoder.sv
/*
 * MMIO address decoder
 * Turns an accepted bus request into one registered select pulse and
 * holds off further selects until the response has been returned.
 */

`timescale 1ns/10ps

module mmio_decoder (
    input  logic                   vdp_clk,
    input  logic                   vdp_reset,
    input  mmio_bus_pkg::mmio_req_t req,
    input  logic                   ready,
    output mmio_bus_pkg::mmio_sel_t sel
);
    import mmio_bus_pkg::*;

    logic [REGION_MSB-REGION_LSB:0] region;
    mmio_sel_t                      decoded;
    logic                           busy;
    logic                           accept;

    assign region = req.address[REGION_MSB:REGION_LSB];

    // a held valid is ignored while the current access is in flight
    assign accept = req.valid && !busy;

    always_comb begin
        decoded       = '0;
        decoded.write = |req.wstrb;

        case (region)
            REGION_STATUS: decoded.status = 1'b1;
            REGION_DSP:    decoded.dsp    = 1'b1;
            REGION_PAD:    decoded.pad    = 1'b1;
            REGION_COP:    decoded.cop    = 1'b1;
            // unmapped, still answered so the master never hangs
            default:       decoded.none   = 1'b1;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            sel  <= '0;
            busy <= 1'b0;
        end else begin
            sel <= '0;

            if (accept) begin
                sel  <= decoded;
                busy <= 1'b1;
            end else if (ready) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- src/mmio_periph_pkg.sv
/*
 * Peripheral register layout
 * Button struct, LED reset value and the bit positions used by the
 * dsp operand select and the gamepad control register.
 */

package mmio_periph_pkg;

    // raw button levels, high when pressed
    typedef struct packed {
        logic left;
        logic right;
        logic b;
    } pad_buttons_t;

    // red LED on after reset
    localparam logic [1:0] STATUS_RESET = 2'b01;

    // address bit 2 picks operand b
    localparam int DSP_SEL_BIT = 2;

    // pad control write layout
    localparam int PAD_LATCH_BIT = 0;
    localparam int PAD_CLK_BIT   = 1;

    localparam int PAD_SHIFT_W = 16;

endpackage

//--- src/mmio_read_mux.sv
/*
 * MMIO response mux
 * Registers the ready pulse one cycle after a select and returns the
 * read data of the selected region. Writes and unmapped reads give zero.
 */

`timescale 1ns/10ps

module mmio_read_mux (
    input  logic                    vdp_clk,
    input  logic                    vdp_reset,
    input  mmio_bus_pkg::mmio_sel_t sel,
    input  logic [1:0]              status,
    input  logic [31:0]             dsp_result,
    input  logic                    pad_bit,
    output mmio_bus_pkg::mmio_rsp_t rsp
);

    logic        ready_next;
    logic [31:0] read_next;
    logic        ready_q;
    logic [31:0] read_data_q;

    // every region answers, including cop and unmapped
    assign ready_next = sel.status || sel.dsp || sel.pad || sel.cop || sel.none;

    always_comb begin
        read_next = '0;

        if (!sel.write) begin
            if (sel.status) begin
                read_next = {30'b0, status};
            end else if (sel.dsp) begin
                read_next = dsp_result;
            end else if (sel.pad) begin
                read_next = {31'b0, pad_bit};
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= ready_next;
        end
    end

    // read data register
    always_ff @(posedge vdp_clk) begin
        read_data_q <= read_next;
    end

    assign rsp.ready     = ready_q;
    assign rsp.read_data = read_data_q;

endmodule

//--- src/mmio_subsystem.sv
/*
 * MMIO peripheral subsystem
 * Address decoder, response mux, dsp multiplier, LED and gamepad ports
 * and the copper RAM, all on the video clock.
 */

`timescale 1ns/10ps

module mmio_subsystem (
    input  logic                                vdp_clk,
    input  logic                                vdp_reset,
    input  mmio_bus_pkg::mmio_req_t             req,
    output mmio_bus_pkg::mmio_rsp_t             rsp,
    input  mmio_periph_pkg::pad_buttons_t       buttons,
    output logic                                led_r,
    output logic                                led_b,
    input  logic                                cop_read_en,
    input  logic [mmio_bus_pkg::COP_ADDR_W-1:0] cop_read_address,
    output logic [15:0]                         cop_read_data
);
    import mmio_bus_pkg::*;
    import mmio_periph_pkg::*;

    mmio_sel_t             sel;
    logic [1:0]            status;
    logic [31:0]           dsp_result;
    logic                  pad_bit;
    logic [COP_ADDR_W-1:0] cop_write_address;

    mmio_decoder decoder (
        .vdp_clk  (vdp_clk),
        .vdp_reset(vdp_reset),
        .req      (req),
        .ready    (rsp.ready),
        .sel      (sel)
    );

    mmio_read_mux read_mux (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .sel       (sel),
        .status    (status),
        .dsp_result(dsp_result),
        .pad_bit   (pad_bit),
        .rsp       (rsp)
    );

    dsp_mult mult (
        .vdp_clk      (vdp_clk),
        .sel_dsp      (sel.dsp),
        .write        (sel.write),
        .operand_b_sel(req.address[DSP_SEL_BIT]),
        .write_data   (req.write_data[15:0]),
        .result       (dsp_result)
    );

    io_ports ports (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .sel_status(sel.status),
        .sel_pad   (sel.pad),
        .write     (sel.write),
        .write_data(req.write_data[1:0]),
        .buttons   (buttons),
        .status    (status),
        .led_r     (led_r),
        .led_b     (led_b),
        .pad_bit   (pad_bit)
    );

    // word address, wstrb[2] picks the upper halfword slot
    assign cop_write_address = {req.address[11:2], req.wstrb[2]};

    cop_ram copper_ram (
        .vdp_clk      (vdp_clk),
        .write_en     (sel.cop && sel.write),
        .write_address(cop_write_address),
        .write_data   (req.write_data[15:0]),
        .read_en      (cop_read_en),
        .read_address (cop_read_address),
        .read_data    (cop_read_data)
    );

endmodule
